// File: src/menu_game_consts.svh
// Timing constants shared by the menu game blocks
// ROUND_CYCLES, BYTE_GAP and SYNC_STAGES must all be at least 1

`ifndef MENU_GAME_CONSTS_SVH
`define MENU_GAME_CONSTS_SVH

// Length of one game round in clock cycles
`define MENU_GAME_ROUND_CYCLES 2000

// Cycles between the two byte strobes of a frame, and after the last one
`define MENU_GAME_BYTE_GAP 16

// Flops in each button synchronizer
`define MENU_GAME_SYNC_STAGES 2

`endif

// File: src/menu_game_pkg.sv
// Types shared by the menu game blocks
// Screen codes are 1 to 4, score saturates at 255
`default_nettype none

package menu_game_pkg;

        typedef logic [7:0] screen_t;
        typedef logic [7:0] score_t;
        typedef logic [7:0] tx_byte_t;

        // Encodings match the debug codes the host tools expect
        typedef enum logic [4:0] {
                st_initial           = 5'd0,
                st_main_menu         = 5'd1,
                st_latch_main        = 5'd2,
                st_send_main_shot    = 5'd3,
                st_wait_main_shot    = 5'd4,
                st_start_round       = 5'd5,
                st_wait_round        = 5'd6,
                st_end_screen        = 5'd7,
                st_latch_end         = 5'd8,
                st_send_end_shot     = 5'd9,
                st_wait_end_shot     = 5'd10,
                st_score_entry       = 5'd11,
                st_latch_entry       = 5'd12,
                st_send_entry        = 5'd13,
                st_wait_entry        = 5'd14,
                st_send_main_special = 5'd15,
                st_wait_main_special = 5'd16,
                st_score_view        = 5'd17,
                st_latch_view        = 5'd18,
                st_send_view         = 5'd19,
                st_wait_view         = 5'd20,
                st_send_end_special  = 5'd21,
                st_wait_end_special  = 5'd22,
                st_choose_main       = 5'd23,
                st_choose_end        = 5'd24,
                st_choose_entry      = 5'd25,
                st_choose_view       = 5'd26,
                st_restart_round     = 5'd27,
                st_error             = 5'd31
        } menu_state_t;

endpackage

`default_nettype wire

// File: src/button_decode.sv
// Button capture: synchronizer plus rising-edge detect per button
// Buttons are assumed bounce free, press lags an edge by SYNC_STAGES + 1 cycles
`timescale 1ns/1ps
`default_nettype none
`include "menu_game_consts.svh"

module button_decode (
        input wire clock,
        input wire reset,
        input wire shot,
        input wire special,
        input wire latch_button,
        input wire clear_button,
        output logic press,
        output logic shot_sync,
        output logic last_shot,
        output logic last_special
);
        localparam int stages = `MENU_GAME_SYNC_STAGES;

        // Bit 0 is shot, bit 1 is special
        logic [stages-1:0][1:0] sync_q;
        logic [1:0] sync_level;
        logic [1:0] prev_q;
        logic [1:0] last_q;

        assign sync_level = sync_q[stages-1];

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        sync_q <= '0;
                end else begin
                        sync_q[0] <= {special, shot};
                        for (int i = 1; i < stages; i++) begin
                                sync_q[i] <= sync_q[i-1];
                        end
                end
        end

        // Either button rising gives one press pulse
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        prev_q <= 2'b00;
                        press <= 1'b0;
                end else begin
                        prev_q <= sync_level;
                        press <= |(sync_level & ~prev_q);
                end
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        last_q <= 2'b00;
                else if (clear_button)
                        last_q <= 2'b00;
                else if (latch_button)
                        last_q <= sync_level;
        end

        assign shot_sync = sync_level[0];
        assign last_shot = last_q[0];
        assign last_special = last_q[1];

endmodule

`default_nettype wire

// File: src/menu_control.sv
// Menu FSM, Moore style, one state per clock
// send comes 3 cycles after press, then waits for send_done before moving on
`timescale 1ns/1ps
`default_nettype none

module menu_control (
        input wire clock,
        input wire reset,
        input wire press,
        input wire last_shot,
        input wire last_special,
        input wire send_done,
        input wire round_done,
        output logic latch_button,
        output logic clear_button,
        output logic send,
        output logic round_start,
        output logic round_clear,
        output logic round_active,
        output menu_game_pkg::screen_t screen,
        output menu_game_pkg::menu_state_t state
);
        import menu_game_pkg::*;

        localparam screen_t screen_main = 8'd1;
        localparam screen_t screen_view = 8'd2;
        localparam screen_t screen_end = 8'd3;
        localparam screen_t screen_entry = 8'd4;

        menu_state_t state_q;
        menu_state_t state_d;

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        state_q <= st_initial;
                else
                        state_q <= state_d;
        end

        always_comb begin
                case (state_q)
                        st_initial:           state_d = st_main_menu;
                        // Main menu
                        st_main_menu:         state_d = press ? st_latch_main : st_main_menu;
                        st_latch_main:        state_d = st_choose_main;
                        st_choose_main:       state_d = last_shot ? st_send_main_shot :
                                                        last_special ? st_send_main_special :
                                                        st_main_menu;
                        st_send_main_shot:    state_d = st_wait_main_shot;
                        st_wait_main_shot:    state_d = send_done ? st_restart_round
                                                                  : st_wait_main_shot;
                        st_send_main_special: state_d = st_wait_main_special;
                        st_wait_main_special: state_d = send_done ? st_score_view
                                                                  : st_wait_main_special;
                        // Game round
                        st_restart_round:     state_d = st_start_round;
                        st_start_round:       state_d = st_wait_round;
                        st_wait_round:        state_d = round_done ? st_end_screen : st_wait_round;
                        // End screen, either button moves on
                        st_end_screen:        state_d = press ? st_latch_end : st_end_screen;
                        st_latch_end:         state_d = st_choose_end;
                        st_choose_end:        state_d = last_shot ? st_send_end_shot :
                                                        last_special ? st_send_end_special :
                                                        st_end_screen;
                        st_send_end_shot:     state_d = st_wait_end_shot;
                        st_wait_end_shot:     state_d = send_done ? st_score_entry : st_wait_end_shot;
                        st_send_end_special:  state_d = st_wait_end_special;
                        st_wait_end_special:  state_d = send_done ? st_score_entry
                                                                  : st_wait_end_special;
                        // Score entry, shot only
                        st_score_entry:       state_d = press ? st_latch_entry : st_score_entry;
                        st_latch_entry:       state_d = st_choose_entry;
                        st_choose_entry:      state_d = last_shot ? st_send_entry : st_score_entry;
                        st_send_entry:        state_d = st_wait_entry;
                        st_wait_entry:        state_d = send_done ? st_main_menu : st_wait_entry;
                        // Score view, special only
                        st_score_view:        state_d = press ? st_latch_view : st_score_view;
                        st_latch_view:        state_d = st_choose_view;
                        st_choose_view:       state_d = last_special ? st_send_view : st_score_view;
                        st_send_view:         state_d = st_wait_view;
                        st_wait_view:         state_d = send_done ? st_main_menu : st_wait_view;
                        st_error:             state_d = st_initial;
                        default:              state_d = st_error;
                endcase
        end

        always_comb begin
                latch_button = 1'b0;
                clear_button = 1'b0;
                send = 1'b0;
                round_start = 1'b0;
                round_clear = 1'b0;
                round_active = 1'b0;
                case (state_q)
                        st_initial:
                                clear_button = 1'b1;
                        st_latch_main, st_latch_end, st_latch_entry, st_latch_view:
                                latch_button = 1'b1;
                        st_send_main_shot, st_send_main_special, st_send_end_shot,
                        st_send_end_special, st_send_entry, st_send_view:
                                send = 1'b1;
                        st_restart_round:
                                round_clear = 1'b1;
                        st_start_round: begin
                                round_start = 1'b1;
                                round_active = 1'b1;
                        end
                        st_wait_round:
                                round_active = 1'b1;
                        default: ;
                endcase
        end

        // Round states show the main menu code, as does reset
        always_comb begin
                case (state_q)
                        st_score_view, st_latch_view, st_choose_view, st_send_view,
                        st_wait_view:
                                screen = screen_view;
                        st_end_screen, st_latch_end, st_choose_end, st_send_end_shot,
                        st_wait_end_shot, st_send_end_special, st_wait_end_special:
                                screen = screen_end;
                        st_score_entry, st_latch_entry, st_choose_entry, st_send_entry,
                        st_wait_entry:
                                screen = screen_entry;
                        default:
                                screen = screen_main;
                endcase
        end

        assign state = state_q;

endmodule

`default_nettype wire

// File: src/game_round.sv
// Game round timer and shot counter
// round_done pulses exactly ROUND_CYCLES cycles after round_start
// Score holds after the round until round_clear
`timescale 1ns/1ps
`default_nettype none
`include "menu_game_consts.svh"

module game_round (
        input wire clock,
        input wire reset,
        input wire round_start,
        input wire round_clear,
        input wire press,
        input wire shot_sync,
        output logic round_done,
        output menu_game_pkg::score_t score
);
        localparam int round_cycles = `MENU_GAME_ROUND_CYCLES;
        localparam int count_width = $clog2(round_cycles + 1);

        logic running_q;
        logic [count_width-1:0] remain_q;

        assign round_done = running_q && (remain_q == '0);

        // Counts down to zero, done on the zero cycle
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        running_q <= 1'b0;
                        remain_q <= '0;
                end else if (round_start) begin
                        running_q <= 1'b1;
                        remain_q <= count_width'(round_cycles - 1);
                end else if (running_q) begin
                        if (remain_q == '0)
                                running_q <= 1'b0;
                        else
                                remain_q <= remain_q - 1'b1;
                end
        end

        // Only shot presses count, saturating
        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        score <= '0;
                else if (round_clear)
                        score <= '0;
                else if (running_q && press && shot_sync && (score != '1))
                        score <= score + 1'b1;
        end

endmodule

`default_nettype wire

// File: src/screen_sender.sv
// Frame sender: screen byte then score byte as strobes, BYTE_GAP cycles apart
// send_done follows BYTE_GAP cycles after the score byte
// A send while busy is dropped, there is no back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "menu_game_consts.svh"

module screen_sender (
        input wire clock,
        input wire reset,
        input wire send,
        input wire menu_game_pkg::screen_t screen,
        input wire menu_game_pkg::score_t score,
        output menu_game_pkg::tx_byte_t tx_byte,
        output logic tx_strobe,
        output logic send_done
);
        import menu_game_pkg::*;

        localparam int byte_gap = `MENU_GAME_BYTE_GAP;
        localparam int gap_width = $clog2(byte_gap + 1);

        logic busy_q;
        logic [1:0] index_q;
        logic [gap_width-1:0] gap_q;
        tx_byte_t screen_byte_q;
        tx_byte_t score_byte_q;
        logic slot;

        // Index 0 and 1 are the bytes, 2 is the closing gap
        assign slot = busy_q && (gap_q == '0);
        assign tx_strobe = slot && (index_q != 2'd2);
        assign send_done = slot && (index_q == 2'd2);
        assign tx_byte = (index_q == 2'd0) ? screen_byte_q : score_byte_q;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        busy_q <= 1'b0;
                        index_q <= 2'd0;
                        gap_q <= '0;
                end else if (!busy_q) begin
                        if (send) begin
                                busy_q <= 1'b1;
                                index_q <= 2'd0;
                                gap_q <= '0;
                        end
                end else if (gap_q != '0) begin
                        gap_q <= gap_q - 1'b1;
                end else if (index_q == 2'd2) begin
                        busy_q <= 1'b0;
                end else begin
                        index_q <= index_q + 1'b1;
                        gap_q <= gap_width'(byte_gap - 1);
                end
        end

        // Frame contents captured on an accepted send
        always_ff @(posedge clock) begin
                if (send && !busy_q) begin
                        screen_byte_q <= screen;
                        score_byte_q <= score;
                end
        end

endmodule

`default_nettype wire

// File: src/menu_game_top.sv
// Menu game top level
// shot and special are raw asynchronous levels, tx_byte is valid only on tx_strobe
`timescale 1ns/1ps
`default_nettype none

module menu_game_top (
        input wire clock,
        input wire reset,
        input wire shot,
        input wire special,
        output wire menu_game_pkg::screen_t screen,
        output wire menu_game_pkg::tx_byte_t tx_byte,
        output wire tx_strobe,
        output wire round_active,
        output wire menu_game_pkg::menu_state_t debug_state
);
        import menu_game_pkg::*;

        wire press;
        wire shot_sync;
        wire last_shot;
        wire last_special;
        wire latch_button;
        wire clear_button;
        wire send;
        wire send_done;
        wire round_start;
        wire round_clear;
        wire round_done;
        score_t score;

        button_decode i_decode (
                .clock(clock),
                .reset(reset),
                .shot(shot),
                .special(special),
                .latch_button(latch_button),
                .clear_button(clear_button),
                .press(press),
                .shot_sync(shot_sync),
                .last_shot(last_shot),
                .last_special(last_special)
        );

        menu_control i_control (
                .clock(clock),
                .reset(reset),
                .press(press),
                .last_shot(last_shot),
                .last_special(last_special),
                .send_done(send_done),
                .round_done(round_done),
                .latch_button(latch_button),
                .clear_button(clear_button),
                .send(send),
                .round_start(round_start),
                .round_clear(round_clear),
                .round_active(round_active),
                .screen(screen),
                .state(debug_state)
        );

        game_round i_round (
                .clock(clock),
                .reset(reset),
                .round_start(round_start),
                .round_clear(round_clear),
                .press(press),
                .shot_sync(shot_sync),
                .round_done(round_done),
                .score(score)
        );

        screen_sender i_sender (
                .clock(clock),
                .reset(reset),
                .send(send),
                .screen(screen),
                .score(score),
                .tx_byte(tx_byte),
                .tx_strobe(tx_strobe),
                .send_done(send_done)
        );

endmodule

`default_nettype wire

// File: bench/menu_game_tb.sv
// Testbench for the menu game top level
// Waits follow the constants in menu_game_consts.svh, rounds hold at most 20 shots
// Stops at the first mismatch, a watchdog bounds the run
`timescale 1ns/1ps
`default_nettype none
`include "menu_game_consts.svh"

module menu_game_tb;
        import menu_game_pkg::*;

        localparam int round_cycles = `MENU_GAME_ROUND_CYCLES;
        localparam int byte_gap = `MENU_GAME_BYTE_GAP;
        localparam int walk_presses = 40;
        localparam int total_presses = walk_presses + 7;
        localparam int quiet_cycles = 40;
        localparam screen_t screen_main = 8'd1;
        localparam screen_t screen_view = 8'd2;
        localparam screen_t screen_end = 8'd3;
        localparam screen_t screen_entry = 8'd4;

        logic clock;
        logic reset;
        logic shot;
        logic special;
        screen_t screen;
        tx_byte_t tx_byte;
        logic tx_strobe;
        logic round_active;
        menu_state_t debug_state;

        tx_byte_t exp_bytes[$];
        int byte_count = 0;
        int frames_seen = 0;
        screen_t model_screen;
        score_t model_score;

        menu_game_top i_dut (
                .clock(clock),
                .reset(reset),
                .shot(shot),
                .special(special),
                .screen(screen),
                .tx_byte(tx_byte),
                .tx_strobe(tx_strobe),
                .round_active(round_active),
                .debug_state(debug_state)
        );

        initial begin
                clock = 1'b0;
                forever #4 clock = ~clock;
        end

        // Menu rules; a shot on the main menu plays a round and lands on the end screen
        function automatic screen_t next_screen(input screen_t current, input logic is_shot,
                                                output logic sends);
                screen_t next_code;
                next_code = current;
                sends = 1'b0;
                case (current)
                        screen_main: begin
                                sends = 1'b1;
                                next_code = is_shot ? screen_end : screen_view;
                        end
                        screen_view: begin
                                if (!is_shot) begin
                                        sends = 1'b1;
                                        next_code = screen_main;
                                end
                        end
                        screen_end: begin
                                sends = 1'b1;
                                next_code = screen_entry;
                        end
                        screen_entry: begin
                                if (is_shot) begin
                                        sends = 1'b1;
                                        next_code = screen_main;
                                end
                        end
                        default: ;
                endcase
                return next_code;
        endfunction

        // State that waits for a press on a given screen
        function automatic menu_state_t idle_state(input screen_t code);
                menu_state_t waiting;
                case (code)
                        screen_view: waiting = st_score_view;
                        screen_end: waiting = st_end_screen;
                        screen_entry: waiting = st_score_entry;
                        default: waiting = st_main_menu;
                endcase
                return waiting;
        endfunction

        task automatic stop_run(input string reason);
                $display("%s", reason);
                $display("Some tests failed");
                $fatal(1, "Run stopped at the first error");
        endtask

        task automatic check_screen(input screen_t got, input screen_t expected);
                if (got !== expected)
                        stop_run($sformatf("ERR screen: got %h, expected %h", got, expected));
        endtask

        task automatic check_byte(input tx_byte_t got, input tx_byte_t expected);
                if (got !== expected)
                        stop_run($sformatf("ERR tx_byte: got %h, expected %h", got, expected));
        endtask

        task automatic check_score(input score_t got, input score_t expected);
                if (got !== expected)
                        stop_run($sformatf("ERR score: got %h, expected %h", got, expected));
        endtask

        task automatic check_state(input menu_state_t got, input menu_state_t expected);
                if (got !== expected)
                        stop_run($sformatf("ERR debug_state: got %h, expected %h",
                                           got, expected));
        endtask

        task automatic hold_button(input logic is_shot);
                @(posedge clock);
                #1;
                shot = is_shot;
                special = !is_shot;
                repeat (4) @(posedge clock);
                #1;
                shot = 1'b0;
                special = 1'b0;
                repeat (4) @(posedge clock);
        endtask

        // Second byte seen, then room for send_done and the next state
        task automatic wait_frame(input int frames_before);
                while (frames_seen == frames_before)
                        @(posedge clock);
                repeat (byte_gap + 4) @(posedge clock);
        endtask

        task automatic play_round();
                int shots;
                while (!round_active)
                        @(negedge clock);
                shots = $urandom_range(0, 20);
                model_score = '0;
                for (int i = 0; i < shots; i++) begin
                        hold_button(1'b1);
                        if (model_score != 8'hff)
                                model_score = model_score + 8'd1;
                end
                while (round_active)
                        @(negedge clock);
                @(negedge clock);
                check_score(i_dut.score, model_score);
        endtask

        task automatic press_and_check(input logic is_shot);
                screen_t expected;
                logic sends;
                logic plays_round;
                int frames_before;
                expected = next_screen(model_screen, is_shot, sends);
                plays_round = (model_screen == screen_main) && is_shot;
                frames_before = frames_seen;
                if (sends) begin
                        exp_bytes.push_back(model_screen);
                        exp_bytes.push_back(model_score);
                end
                hold_button(is_shot);
                if (sends)
                        wait_frame(frames_before);
                else
                        repeat (quiet_cycles) @(posedge clock);
                if (plays_round)
                        play_round();
                model_screen = expected;
                @(negedge clock);
                check_screen(screen, model_screen);
                check_state(debug_state, idle_state(model_screen));
        endtask

        // Frame monitor, bytes compared in arrival order
        initial begin
                tx_byte_t expected;
                forever begin
                        @(negedge clock);
                        if (tx_strobe) begin
                                if (exp_bytes.size() == 0) begin
                                        stop_run("A tx_strobe arrived when no frame was expected");
                                end else begin
                                        expected = exp_bytes.pop_front();
                                        check_byte(tx_byte, expected);
                                        byte_count++;
                                        if (byte_count % 2 == 0)
                                                frames_seen++;
                                end
                        end
                end
        end

        // Each press may take one full round plus margin
        initial begin
                repeat (total_presses * (round_cycles + 200)) @(posedge clock);
                stop_run("Timeout: the DUT stopped responding before the tests finished");
        end

        initial begin
                void'($urandom(32'h18c1));
                reset = 1'b1;
                shot = 1'b0;
                special = 1'b0;
                model_screen = screen_main;
                model_score = '0;
                repeat (16) @(posedge clock);
                #1;
                reset = 1'b0;
                repeat (quiet_cycles) @(posedge clock);
                @(negedge clock);
                check_screen(screen, screen_main);
                check_state(debug_state, st_main_menu);
                // Score view, ignored shot, back to main
                press_and_check(1'b0);
                press_and_check(1'b1);
                press_and_check(1'b0);
                // Round, end screen, score entry
                press_and_check(1'b1);
                press_and_check($urandom_range(0, 1) == 1);
                press_and_check(1'b0);
                press_and_check(1'b1);
                for (int i = 0; i < walk_presses; i++)
                        press_and_check($urandom_range(0, 1) == 1);
                repeat (quiet_cycles) @(posedge clock);
                if (exp_bytes.size() != 0) begin
                        stop_run("Frames were expected but never arrived");
                end else begin
                        $display("All tests passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// File: menu_game.f
+incdir+src
src/menu_game_pkg.sv
src/button_decode.sv
src/menu_control.sv
src/game_round.sv
src/screen_sender.sv
src/menu_game_top.sv
bench/menu_game_tb.sv

// File: Makefile
# Verilator build and run for the menu game testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := menu_game_tb
FILELIST  := menu_game.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
